// File: design/decodeStage.sv
// instruction decode and hazard detection
`default_nettype none
`include "proc_config.svh"

module decodeStage #(
   parameter int SEL_W = $clog2(`REG_CNT)
) (
   input  logic               clk,
   input  logic               rstN,
   input  procPkg::instrT     ifInstr,
   input  logic [`DATA_W-1:0] ifPcNext,
   input  logic               ifValid,
   input  logic               stall,
   input  logic               redirect,
   input  logic               wbEn,
   input  logic [SEL_W-1:0]   wbSel,
   input  logic [`DATA_W-1:0] wbData,
   input  logic               exDestValid,
   input  logic [SEL_W-1:0]   exDestSel,
   input  logic               memDestValid,
   input  logic [SEL_W-1:0]   memDestSel,
   output logic               hold,
   output logic               err,
   stageBus.src               idBus
);

   procPkg::ctrlT      decCtrl;
   logic               useA;
   logic               useB;
   logic               illegal;
   logic [SEL_W-1:0]   rdSelB;
   logic [`DATA_W-1:0] rdDataA;
   logic [`DATA_W-1:0] rdDataB;
   logic [`DATA_W-1:0] immExt;
   logic               hitA;
   logic               hitB;
   logic               haltSeen; // younger words are never executed

   always_comb begin
      decCtrl = '0;
      useA    = 1'b0;
      useB    = 1'b0;
      illegal = 1'b0;
      rdSelB  = ifInstr.r.rt;
      case (ifInstr.r.opcode)
         procPkg::opAlu: begin
            decCtrl.aluOp    = ifInstr.r.funct;
            decCtrl.regWrite = 1'b1;
            useA             = 1'b1;
            useB             = 1'b1;
         end
         procPkg::opAddi, procPkg::opLd: begin
            decCtrl.useImm   = 1'b1;
            decCtrl.regWrite = 1'b1;
            decCtrl.memRead  = (ifInstr.i.opcode == procPkg::opLd);
            useA             = 1'b1;
         end
         procPkg::opSt: begin
            decCtrl.useImm   = 1'b1;
            decCtrl.memWrite = 1'b1;
            rdSelB           = ifInstr.i.rd; // store data register
            useA             = 1'b1;
            useB             = 1'b1;
         end
         procPkg::opBeqz, procPkg::opBnez: begin
            decCtrl.useImm        = 1'b1;
            decCtrl.branchZero    = (ifInstr.i.opcode == procPkg::opBeqz);
            decCtrl.branchNonZero = (ifInstr.i.opcode == procPkg::opBnez);
            useA                  = 1'b1;
         end
         procPkg::opNop: ;
         procPkg::opHalt: decCtrl.halt = 1'b1;
         default: illegal = 1'b1; // goes on as a NOP
      endcase
   end

   assign immExt = {{(`DATA_W-6){ifInstr.i.imm[5]}}, ifInstr.i.imm};

   // RAW against execute and memory, writeback is bypassed
   assign hitA = (exDestValid && exDestSel == ifInstr.r.rs) ||
                 (memDestValid && memDestSel == ifInstr.r.rs);
   assign hitB = (exDestValid && exDestSel == rdSelB) ||
                 (memDestValid && memDestSel == rdSelB);
   assign hold = ifValid && !haltSeen && ((useA && hitA) || (useB && hitB));

   regFile rf (
      .clk     (clk),
      .rstN    (rstN),
      .rdSelA  (ifInstr.r.rs),
      .rdSelB  (rdSelB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wbEn),
      .wrSel   (wbSel),
      .wrData  (wbData)
   );

   always_ff @(posedge clk) begin
      if (!rstN) begin
         idBus.valid <= 1'b0;
         idBus.ctrl  <= '0;
         haltSeen    <= 1'b0;
         err         <= 1'b0;
      end else begin
         if (!stall) begin
            if (redirect || hold || !ifValid || haltSeen) begin
               idBus.valid <= 1'b0; // bubble
               idBus.ctrl  <= '0;
            end else begin
               idBus.valid <= 1'b1;
               idBus.ctrl  <= decCtrl;
               haltSeen    <= decCtrl.halt;
               if (illegal) begin
                  err <= 1'b1; // only for a word that really moves on
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         idBus.opA       <= rdDataA;
         idBus.opB       <= decCtrl.useImm ? immExt : rdDataB;
         idBus.storeData <= rdDataB;
         idBus.wrSel     <= ifInstr.r.rd;
         idBus.pcNext    <= ifPcNext;
      end
   end

   // a held word waits in IF/ID until a redirect drops it
   assert property (@(posedge clk) disable iff (!rstN)
      hold && !redirect |=> ifValid && $stable(ifInstr));

endmodule

`default_nettype wire

// File: design/executeStage.sv
// ALU and branch resolution
`default_nettype none
`include "proc_config.svh"

module executeStage (
   input  logic               clk,
   input  logic               rstN,
   input  logic               stall,
   stageBus.dst               idBus,
   stageBus.src               exBus,
   output logic               redirect,
   output logic [`DATA_W-1:0] redirectPc
);

   logic [`DATA_W-1:0] aluRes;
   logic               opAZero;
   logic               taken;

   always_comb begin
      aluRes = idBus.opA + idBus.opB;
      case (idBus.ctrl.aluOp)
         procPkg::aluAdd: aluRes = idBus.opA + idBus.opB;
         procPkg::aluSub: aluRes = idBus.opA - idBus.opB;
         procPkg::aluAnd: aluRes = idBus.opA & idBus.opB;
         procPkg::aluOr:  aluRes = idBus.opA | idBus.opB;
         procPkg::aluXor: aluRes = idBus.opA ^ idBus.opB;
         procPkg::aluSll: aluRes = idBus.opA << idBus.opB[3:0];
         procPkg::aluSrl: aluRes = idBus.opA >> idBus.opB[3:0];
         procPkg::aluSlt: begin
            aluRes = {{(`DATA_W-1){1'b0}}, $signed(idBus.opA) < $signed(idBus.opB)};
         end
         default: aluRes = idBus.opA + idBus.opB;
      endcase
   end

   assign opAZero = (idBus.opA == '0);
   assign taken   = idBus.valid && ((idBus.ctrl.branchZero && opAZero) ||
                                    (idBus.ctrl.branchNonZero && !opAZero));

   // only when the branch actually leaves execute
   assign redirect   = taken && !stall;
   assign redirectPc = idBus.pcNext + idBus.opB; // opB holds the offset

   always_ff @(posedge clk) begin
      if (!rstN) begin
         exBus.valid <= 1'b0;
         exBus.ctrl  <= '0;
      end else if (!stall) begin
         if (!idBus.valid || taken) begin
            exBus.valid <= 1'b0;
            exBus.ctrl  <= '0;
         end else begin
            exBus.valid <= 1'b1;
            exBus.ctrl  <= idBus.ctrl;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         exBus.opA       <= aluRes;  // result or effective address
         exBus.opB       <= idBus.opB;
         exBus.storeData <= idBus.storeData;
         exBus.wrSel     <= idBus.wrSel;
         exBus.pcNext    <= idBus.pcNext;
      end
   end

endmodule

`default_nettype wire

// File: design/fetchStage.sv
// instruction fetch stage
`default_nettype none
`include "proc_config.svh"

module fetchStage #(
   parameter int IMEM_AW = $clog2(`IMEM_DEPTH)
) (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 imemWrEn,
   input  logic [IMEM_AW-1:0]   imemWrAddr,
   input  logic [`DATA_W-1:0]   imemWrData,
   input  logic                 hold,
   input  logic                 stall,
   input  logic                 redirect,
   input  logic [`DATA_W-1:0]   redirectPc,
   input  logic                 halted,
   output procPkg::instrT       ifInstr,
   output logic [`DATA_W-1:0]   ifPcNext,
   output logic                 ifValid
);

   logic [`DATA_W-1:0] imem [`IMEM_DEPTH];
   logic [`DATA_W-1:0] pc;

   // program load, only while in reset
   always_ff @(posedge clk) begin
      if (!rstN && imemWrEn) begin
         imem[imemWrAddr] <= imemWrData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc      <= '0;
         ifValid <= 1'b0;
      end else if (redirect) begin
         pc      <= redirectPc; // branch taken in execute
         ifValid <= 1'b0;
      end else if (stall || hold) begin
         pc      <= pc;
      end else if (halted) begin
         ifValid <= 1'b0;
      end else begin
         ifInstr  <= imem[pc[IMEM_AW-1:0]];
         ifPcNext <= pc + 1'b1;
         ifValid  <= 1'b1;
         pc       <= pc + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: design/memStage.sv
// data memory and writeback
`default_nettype none
`include "proc_config.svh"

module memStage #(
   parameter int SEL_W   = $clog2(`REG_CNT),
   parameter int DMEM_AW = $clog2(`DMEM_DEPTH),
   parameter int CNT_W   = $clog2(`DMEM_LAT + 1)
) (
   input  logic               clk,
   input  logic               rstN,
   stageBus.dst               exBus,
   output logic               stall,
   output logic               wbEn,
   output logic [SEL_W-1:0]   wbSel,
   output logic [`DATA_W-1:0] wbData,
   output logic               halted
);

   localparam logic [CNT_W-1:0] LAT = CNT_W'(`DMEM_LAT);

   logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
   logic [CNT_W-1:0]   latCnt;
   logic               live;
   logic               memOp;
   logic [DMEM_AW-1:0] dmemAddr;
   logic               leaving;

   assign live     = exBus.valid && !halted; // nothing behind HALT takes effect
   assign memOp    = live && (exBus.ctrl.memRead || exBus.ctrl.memWrite);
   assign stall    = memOp && (latCnt != LAT);
   assign leaving  = live && !stall;
   assign dmemAddr = exBus.opA[DMEM_AW-1:0];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         latCnt <= '0;
      end else if (stall) begin
         latCnt <= latCnt + 1'b1;
      end else begin
         latCnt <= '0;
      end
   end

   // access completes on the last wait cycle
   always_ff @(posedge clk) begin
      if (leaving && exBus.ctrl.memWrite) begin
         dmem[dmemAddr] <= exBus.storeData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbEn <= leaving && exBus.ctrl.regWrite; // one pulse per slot
         if (leaving && exBus.ctrl.halt) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      wbSel  <= exBus.wrSel;
      wbData <= exBus.ctrl.memRead ? dmem[dmemAddr] : exBus.opA;
   end

   // counter bounded, and running only while the access is still held in EX/MEM
   assert property (@(posedge clk) disable iff (!rstN)
      latCnt <= LAT && (latCnt == '0 || memOp));

endmodule

`default_nettype wire

// File: design/proc.sv
// five-stage processor top
`default_nettype none
`include "proc_config.svh"

module proc #(
   parameter int IMEM_AW = $clog2(`IMEM_DEPTH),
   parameter int SEL_W   = $clog2(`REG_CNT)
) (
   input  logic               clk,
   input  logic               rstN,
   input  logic               imemWrEn,
   input  logic [IMEM_AW-1:0] imemWrAddr,
   input  logic [`DATA_W-1:0] imemWrData,
   output logic               retireValid,
   output logic [SEL_W-1:0]   retireSel,
   output logic [`DATA_W-1:0] retireData,
   output logic               halted,
   output logic               err
);

   procPkg::instrT     ifInstr;
   logic [`DATA_W-1:0] ifPcNext;
   logic               ifValid;
   logic               hold;
   logic               stall;
   logic               redirect;
   logic [`DATA_W-1:0] redirectPc;

   stageBus idBus ();   // ID/EX
   stageBus exBus ();   // EX/MEM

   fetchStage fetch (
      .clk        (clk),
      .rstN       (rstN),
      .imemWrEn   (imemWrEn),
      .imemWrAddr (imemWrAddr),
      .imemWrData (imemWrData),
      .hold       (hold),
      .stall      (stall),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .halted     (halted),
      .ifInstr    (ifInstr),
      .ifPcNext   (ifPcNext),
      .ifValid    (ifValid)
   );

   // bubbles carry a cleared ctrl, so regWrite alone marks a pending write
   decodeStage decode (
      .clk          (clk),
      .rstN         (rstN),
      .ifInstr      (ifInstr),
      .ifPcNext     (ifPcNext),
      .ifValid      (ifValid),
      .stall        (stall),
      .redirect     (redirect),
      .wbEn         (retireValid),
      .wbSel        (retireSel),
      .wbData       (retireData),
      .exDestValid  (idBus.ctrl.regWrite),
      .exDestSel    (idBus.wrSel),
      .memDestValid (exBus.ctrl.regWrite),
      .memDestSel   (exBus.wrSel),
      .hold         (hold),
      .err          (err),
      .idBus        (idBus.src)
   );

   executeStage execute (
      .clk        (clk),
      .rstN       (rstN),
      .stall      (stall),
      .idBus      (idBus.dst),
      .exBus      (exBus.src),
      .redirect   (redirect),
      .redirectPc (redirectPc)
   );

   memStage mem (
      .clk    (clk),
      .rstN   (rstN),
      .exBus  (exBus.dst),
      .stall  (stall),
      .wbEn   (retireValid),
      .wbSel  (retireSel),
      .wbData (retireData),
      .halted (halted)
   );

endmodule

`default_nettype wire

// File: design/procPkg.sv
// processor pipeline types
`default_nettype none

package procPkg;

   typedef enum logic [3:0] {
      opNop  = 4'h0,
      opAlu  = 4'h1, // register-register, op in funct
      opAddi = 4'h2,
      opLd   = 4'h3,
      opSt   = 4'h4,
      opBeqz = 4'h5,
      opBnez = 4'h6,
      opHalt = 4'hf
   } opcodeT;

   typedef enum logic [2:0] {
      aluAdd = 3'd0,
      aluSub = 3'd1,
      aluAnd = 3'd2,
      aluOr  = 3'd3,
      aluXor = 3'd4,
      aluSll = 3'd5,
      aluSrl = 3'd6,
      aluSlt = 3'd7
   } aluOpT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      aluOpT      funct;
   } rViewT;

   typedef struct packed {
      opcodeT            opcode;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic signed [5:0] imm;
   } iViewT;

   // same word, register or immediate layout
   typedef union packed {
      rViewT r;
      iViewT i;
   } instrT;

   typedef struct packed {
      aluOpT aluOp;
      logic  useImm;
      logic  regWrite;
      logic  memRead;
      logic  memWrite;
      logic  branchZero;
      logic  branchNonZero;
      logic  halt;
   } ctrlT;

endpackage

`default_nettype wire

// File: design/regFile.sv
// register file with write bypass
`default_nettype none
`include "proc_config.svh"

module regFile #(
   parameter int SEL_W = $clog2(`REG_CNT)
) (
   input  logic               clk,
   input  logic               rstN,
   input  logic [SEL_W-1:0]   rdSelA,
   input  logic [SEL_W-1:0]   rdSelB,
   output logic [`DATA_W-1:0] rdDataA,
   output logic [`DATA_W-1:0] rdDataB,
   input  logic               wrEn,
   input  logic [SEL_W-1:0]   wrSel,
   input  logic [`DATA_W-1:0] wrData
);

   logic [`DATA_W-1:0] regs [`REG_CNT];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   // writeback in the same cycle wins
   assign rdDataA = (wrEn && wrSel == rdSelA) ? wrData : regs[rdSelA];
   assign rdDataB = (wrEn && wrSel == rdSelB) ? wrData : regs[rdSelB];

endmodule

`default_nettype wire

// File: design/stageBus.sv
// pipeline slot between stages
`default_nettype none
`include "proc_config.svh"

interface stageBus;
   logic                         valid;
   procPkg::ctrlT                ctrl;
   logic [`DATA_W-1:0]           opA;
   logic [`DATA_W-1:0]           opB;
   logic [`DATA_W-1:0]           storeData;
   logic [$clog2(`REG_CNT)-1:0]  wrSel;
   logic [`DATA_W-1:0]           pcNext;   // incremented PC

   modport src (output valid, ctrl, opA, opB, storeData, wrSel, pcNext);
   modport dst (input valid, ctrl, opA, opB, storeData, wrSel, pcNext);
endinterface

`default_nettype wire

// File: include/proc_config.svh
// processor configuration
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// word width of registers, memories and PC
`define DATA_W 16

// register file size
`define REG_CNT 8

// memory depths in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// cycles per data memory access
`define DMEM_LAT 2

`endif

// File: sources.f
+incdir+include
design/procPkg.sv
design/stageBus.sv
design/regFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memStage.sv
design/proc.sv
tests/procTb.sv

// File: tests/procTb.sv
// processor pipeline testbench
`default_nettype none
`include "proc_config.svh"

module procTb;

   localparam int IMEM_AW     = $clog2(`IMEM_DEPTH);
   localparam int RUNS        = 3;
   localparam int PROG_LEN    = 16;  // one word per reset cycle
   localparam int RETIRE_WAIT = 80;
   localparam int HALT_WAIT   = 40;
   localparam int QUIET_SPAN  = 24;  // cycles watched after halt

   logic                 clk = 1'b0;
   logic                 rstN;
   logic                 imemWrEn;
   logic [IMEM_AW-1:0]   imemWrAddr;
   logic [`DATA_W-1:0]   imemWrData;
   logic                 retireValid;
   logic [2:0]           retireSel;
   logic [`DATA_W-1:0]   retireData;
   logic                 halted;
   logic                 err;

   logic [`DATA_W-1:0]   progTable [RUNS*PROG_LEN];
   logic [2:0]           expSel [$];
   logic [`DATA_W-1:0]   expData [$];
   int                   expCount [RUNS];
   logic                 expErr [RUNS];

   proc proc_inst (
      .clk         (clk),
      .rstN        (rstN),
      .imemWrEn    (imemWrEn),
      .imemWrAddr  (imemWrAddr),
      .imemWrData  (imemWrData),
      .retireValid (retireValid),
      .retireSel   (retireSel),
      .retireData  (retireData),
      .halted      (halted),
      .err         (err)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   function automatic logic [`DATA_W-1:0] encodeR(input logic [3:0] op,
         input logic [2:0] rd, rs, rt, funct);
      return {op, rd, rs, rt, funct};
   endfunction

   function automatic logic [`DATA_W-1:0] encodeI(input logic [3:0] op,
         input logic [2:0] rd, rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic logic [`DATA_W-1:0] signExtend(input logic [5:0] v);
      return {{(`DATA_W-6){v[5]}}, v};
   endfunction

   function automatic logic [`DATA_W-1:0] signedLess(input logic [`DATA_W-1:0] x, y);
      return ($signed(x) < $signed(y)) ? 16'd1 : 16'd0;
   endfunction

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
         input logic [31:0] expected);
      if (actual !== expected) begin
         abortRun($sformatf("mismatch at time %0t: %s is %0h, expected %0h",
            $time, name, actual, expected));
      end
   endtask

   task automatic addExpect(input int run, input logic [2:0] sel,
         input logic [`DATA_W-1:0] data);
      expSel.push_back(sel);
      expData.push_back(data);
      expCount[run]++;
   endtask

   task automatic buildTables();
      logic [5:0]         immA;
      logic [5:0]         immB;
      logic [5:0]         immC;
      logic [5:0]         immD;
      logic [`DATA_W-1:0] a;
      logic [`DATA_W-1:0] b;
      logic [`DATA_W-1:0] r1;
      logic [`DATA_W-1:0] r2;
      logic [`DATA_W-1:0] r3;
      immA = 6'($urandom);
      immB = 6'($urandom);
      immC = 6'($urandom);
      immD = 6'($urandom);
      for (int i = 0; i < RUNS*PROG_LEN; i++) begin
         progTable[i] = '0; // NOP fill
      end
      for (int i = 0; i < RUNS; i++) begin
         expCount[i] = 0;
      end

      // run 0, every ALU funct on two random operands
      a = signExtend(immA);
      b = signExtend(immB);
      progTable[0]  = encodeI(procPkg::opAddi, 3'd1, 3'd0, immA);
      progTable[1]  = encodeI(procPkg::opAddi, 3'd2, 3'd0, immB);
      progTable[2]  = encodeR(procPkg::opAlu, 3'd3, 3'd1, 3'd2, procPkg::aluAdd);
      progTable[3]  = encodeR(procPkg::opAlu, 3'd4, 3'd1, 3'd2, procPkg::aluSub);
      progTable[4]  = encodeR(procPkg::opAlu, 3'd5, 3'd1, 3'd2, procPkg::aluAnd);
      progTable[5]  = encodeR(procPkg::opAlu, 3'd6, 3'd1, 3'd2, procPkg::aluOr);
      progTable[6]  = encodeR(procPkg::opAlu, 3'd7, 3'd1, 3'd2, procPkg::aluXor);
      progTable[7]  = encodeR(procPkg::opAlu, 3'd3, 3'd1, 3'd2, procPkg::aluSll);
      progTable[8]  = encodeR(procPkg::opAlu, 3'd4, 3'd1, 3'd2, procPkg::aluSrl);
      progTable[9]  = encodeR(procPkg::opAlu, 3'd5, 3'd1, 3'd2, procPkg::aluSlt);
      progTable[10] = encodeR(procPkg::opAlu, 3'd6, 3'd2, 3'd1, procPkg::aluSlt);
      progTable[11] = encodeI(procPkg::opHalt, 3'd0, 3'd0, 6'd0);
      for (int i = 12; i < PROG_LEN; i++) begin
         progTable[i] = encodeI(procPkg::opAddi, 3'd7, 3'd0, 6'(i)); // behind HALT
      end
      addExpect(0, 3'd1, a);
      addExpect(0, 3'd2, b);
      addExpect(0, 3'd3, a + b);
      addExpect(0, 3'd4, a - b);
      addExpect(0, 3'd5, a & b);
      addExpect(0, 3'd6, a | b);
      addExpect(0, 3'd7, a ^ b);
      addExpect(0, 3'd3, a << b[3:0]);
      addExpect(0, 3'd4, a >> b[3:0]);
      addExpect(0, 3'd5, signedLess(a, b));
      addExpect(0, 3'd6, signedLess(b, a));
      expErr[0] = 1'b0;

      // run 1, dependent chain, store then load, branches
      r1 = signExtend(immC) + 16'd1;
      r2 = r1 + signExtend(immD);
      r3 = r1 + r2;
      progTable[16] = encodeI(procPkg::opAddi, 3'd1, 3'd0, immC);
      progTable[17] = encodeI(procPkg::opAddi, 3'd1, 3'd1, 6'd1);
      progTable[18] = encodeI(procPkg::opAddi, 3'd2, 3'd1, immD);
      progTable[19] = encodeR(procPkg::opAlu, 3'd3, 3'd1, 3'd2, procPkg::aluAdd);
      progTable[20] = encodeI(procPkg::opSt, 3'd3, 3'd0, 6'd5);   // mem[5] = r3
      progTable[21] = encodeI(procPkg::opLd, 3'd4, 3'd0, 6'd5);
      progTable[22] = encodeI(procPkg::opAddi, 3'd6, 3'd0, 6'd9);
      progTable[23] = encodeI(procPkg::opBeqz, 3'd0, 3'd0, 6'd2); // taken, to 10
      progTable[24] = encodeI(procPkg::opAddi, 3'd5, 3'd0, 6'd1);
      progTable[25] = encodeI(procPkg::opAddi, 3'd5, 3'd0, 6'd2);
      progTable[26] = encodeI(procPkg::opBnez, 3'd0, 3'd6, 6'd1); // taken, to 12
      progTable[27] = encodeI(procPkg::opAddi, 3'd5, 3'd0, 6'd3);
      progTable[28] = encodeI(procPkg::opBnez, 3'd0, 3'd0, 6'd2); // falls through
      progTable[29] = encodeI(procPkg::opBeqz, 3'd0, 3'd6, 6'd1); // falls through
      progTable[30] = encodeI(procPkg::opAddi, 3'd7, 3'd4, 6'd1);
      progTable[31] = encodeI(procPkg::opHalt, 3'd0, 3'd0, 6'd0);
      addExpect(1, 3'd1, signExtend(immC));
      addExpect(1, 3'd1, r1);
      addExpect(1, 3'd2, r2);
      addExpect(1, 3'd3, r3);
      addExpect(1, 3'd4, r3);
      addExpect(1, 3'd6, 16'd9);
      addExpect(1, 3'd7, r3 + 16'd1);
      expErr[1] = 1'b0;

      // run 2, unassigned opcode 7 in the middle
      progTable[32] = encodeI(procPkg::opAddi, 3'd1, 3'd0, 6'd4);
      progTable[33] = {4'h7, 12'h249};
      progTable[34] = encodeI(procPkg::opAddi, 3'd2, 3'd1, 6'd3);
      progTable[35] = encodeI(procPkg::opHalt, 3'd0, 3'd0, 6'd0);
      addExpect(2, 3'd1, 16'd4);
      addExpect(2, 3'd2, 16'd7);
      expErr[2] = 1'b1;
   endtask

   // program load happens only while in reset
   task automatic loadAndReset(input int run);
      rstN = 1'b0;
      for (int i = 0; i < PROG_LEN; i++) begin
         imemWrEn   = 1'b1;
         imemWrAddr = IMEM_AW'(i);
         imemWrData = progTable[run*PROG_LEN + i];
         @(negedge clk);
      end
      imemWrEn = 1'b0;
      rstN     = 1'b1;
      checkValue("retireValid", retireValid, 0);
      checkValue("halted", halted, 0);
      checkValue("err", err, 0);
   endtask

   task automatic waitRetire();
      int cycles = 0;
      @(negedge clk);
      while (retireValid !== 1'b1) begin
         if (cycles == RETIRE_WAIT) begin
            abortRun("timeout: no retire record within the cycle limit");
         end
         cycles++;
         @(negedge clk);
      end
   endtask

   task automatic checkRetires(input int run);
      logic [2:0]         wantSel;
      logic [`DATA_W-1:0] wantData;
      for (int k = 0; k < expCount[run]; k++) begin
         waitRetire();
         wantSel  = expSel.pop_front();
         wantData = expData.pop_front();
         checkValue("retireSel", retireSel, wantSel);
         checkValue("retireData", retireData, wantData);
         checkValue("halted", halted, 0);
      end
   endtask

   task automatic waitHalted();
      int cycles = 0;
      @(negedge clk);
      while (halted !== 1'b1) begin
         if (retireValid) begin
            abortRun("an extra retire record came before halt");
         end
         if (cycles == HALT_WAIT) begin
            abortRun("timeout: halted never rose");
         end
         cycles++;
         @(negedge clk);
      end
   endtask

   // nothing retires once halted, err keeps its value
   task automatic checkQuiet(input int run);
      repeat (QUIET_SPAN) begin
         @(negedge clk);
         checkValue("retireValid", retireValid, 0);
         checkValue("halted", halted, 1);
         checkValue("err", err, expErr[run]);
      end
   endtask

   initial begin
      rstN       = 1'b0;
      imemWrEn   = 1'b0;
      imemWrAddr = '0;
      imemWrData = '0;
      void'($urandom(32'hf9fc));
      buildTables();
      for (int run = 0; run < RUNS; run++) begin
         loadAndReset(run);
         checkRetires(run);
         waitHalted();
         checkQuiet(run);
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire
